/* design/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter #(
	parameter int RAM_AW = 8
) (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	// memory stage
	input  logic                           pipe_req_i,
	input  logic                           pipe_we_i,
	input  logic [RAM_AW-1:0]              pipe_addr_i,
	input  logic [mem_bus_pkg::BE_W-1:0]   pipe_be_i,
	input  logic [mem_bus_pkg::DATA_W-1:0] pipe_wdata_i,
	output logic                           pipe_gnt_o,
	// host port
	input  logic                           host_req_i,
	input  logic                           host_we_i,
	input  logic [RAM_AW-1:0]              host_addr_i,
	input  logic [mem_bus_pkg::BE_W-1:0]   host_be_i,
	input  logic [mem_bus_pkg::DATA_W-1:0] host_wdata_i,
	output logic                           host_gnt_o,
	// RAM side
	output logic                           ram_en_o,
	output logic                           ram_we_o,
	output logic [RAM_AW-1:0]              ram_addr_o,
	output logic [mem_bus_pkg::BE_W-1:0]   ram_be_o,
	output logic [mem_bus_pkg::DATA_W-1:0] ram_wdata_o,
	input  logic [mem_bus_pkg::DATA_W-1:0] rdata_i,
	output logic [mem_bus_pkg::DATA_W-1:0] rdata_o
);

	mem_bus_pkg::req_id_e last_q, pend_id_q, sel;
	logic pend_v_q;
	logic pipe_elig, host_elig;

	// a requester whose access is already in the RAM waits for its grant
	assign pipe_elig = pipe_req_i && !(pend_v_q && pend_id_q == mem_bus_pkg::req_pipe);
	assign host_elig = host_req_i && !(pend_v_q && pend_id_q == mem_bus_pkg::req_host);

	always_comb begin
		sel = mem_bus_pkg::req_pipe;
		if (pipe_elig && host_elig) begin
			if (last_q == mem_bus_pkg::req_pipe) sel = mem_bus_pkg::req_host;	// take turns
		end else if (host_elig) begin
			sel = mem_bus_pkg::req_host;
		end
	end

	// ==================================================
	// RAM command mux
	// ==================================================

	assign ram_en_o    = pipe_elig || host_elig;
	assign ram_we_o    = ram_en_o && ((sel == mem_bus_pkg::req_host) ? host_we_i : pipe_we_i);
	assign ram_addr_o  = (sel == mem_bus_pkg::req_host) ? host_addr_i : pipe_addr_i;
	assign ram_be_o    = (sel == mem_bus_pkg::req_host) ? host_be_i : pipe_be_i;
	assign ram_wdata_o = (sel == mem_bus_pkg::req_host) ? host_wdata_i : pipe_wdata_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pend_v_q  <= 1'b0;
			pend_id_q <= mem_bus_pkg::req_pipe;
			last_q    <= mem_bus_pkg::req_host;
		end else begin
			pend_v_q <= ram_en_o;
			if (ram_en_o) begin
				pend_id_q <= sel;
				last_q    <= sel;
			end
		end
	end

	// grant pulses with the returning data
	assign pipe_gnt_o = pend_v_q && (pend_id_q == mem_bus_pkg::req_pipe);
	assign host_gnt_o = pend_v_q && (pend_id_q == mem_bus_pkg::req_host);
	assign rdata_o    = rdata_i;

endmodule

/* design/data_ram.sv */
`timescale 1ns/100ps

module data_ram #(
	parameter int RAM_AW = 8
) (
	input  logic                             clk_i,
	input  logic                             en_i,
	input  logic                             we_i,
	input  logic [RAM_AW-1:0]                addr_i,
	input  logic [mem_bus_pkg::BE_W-1:0]     be_i,
	input  logic [mem_bus_pkg::DATA_W-1:0]   wdata_i,
	output logic [mem_bus_pkg::DATA_W-1:0]   rdata_o
);

	localparam int DEPTH = 2 ** RAM_AW;

	logic [mem_bus_pkg::DATA_W-1:0] mem [DEPTH];

	// ==================================================
	// byte-masked write
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (en_i && we_i) begin
			for (int b = 0; b < mem_bus_pkg::BE_W; b++) begin
				if (be_i[b]) begin
					mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

	// ==================================================
	// registered read, data valid the next cycle
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (en_i) begin
			rdata_o <= mem[addr_i];	// old word on a write cycle
		end
	end

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

	// ==================================================
	// data bus between the stages, the host and the RAM
	// ==================================================

	localparam int DATA_W   = 32;	// bus data width
	localparam int BE_W     = DATA_W / 8;	// one enable per byte lane
	localparam int ADDR_LSB = 2;	// byte offset bits below the word address

	// who owns the RAM in a given cycle
	typedef enum logic {
		req_pipe = 1'b0,
		req_host = 1'b1
	} req_id_e;

endpackage

/* design/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage #(
	parameter int RAM_AW = 8
) (
	input  logic                                  clk_i,
	input  logic                                  rst_n_i,
	// instruction from execute
	input  logic                                  instr_valid_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      alu_i,
	input  logic                                  br_en_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      pc_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0]    rd_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0]    rs2_i,
	input  logic                                  load_regfile_i,
	input  logic                                  mem_read_i,
	input  logic                                  mem_write_i,
	input  rv32i_types_pkg::width_e               width_i,
	input  rv32i_types_pkg::regfilemux_sel_e      regfilemux_sel_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      u_imm_i,
	output logic                                  stall_o,
	// store data read
	output logic [rv32i_types_pkg::REG_AW-1:0]    rs2_addr_o,
	input  logic [rv32i_types_pkg::XLEN-1:0]      rs2_data_i,
	// RAM request
	output logic                                  req_o,
	output logic                                  we_o,
	output logic [RAM_AW-1:0]                     addr_o,
	output logic [mem_bus_pkg::BE_W-1:0]          be_o,
	output logic [mem_bus_pkg::DATA_W-1:0]        wdata_o,
	input  logic                                  gnt_i,
	input  logic [mem_bus_pkg::DATA_W-1:0]        rdata_i,
	// to writeback
	output logic                                  wb_valid_o,
	output logic [rv32i_types_pkg::XLEN-1:0]      wb_alu_o,
	output logic                                  wb_br_en_o,
	output logic [rv32i_types_pkg::XLEN-1:0]      wb_pc_o,
	output logic [rv32i_types_pkg::REG_AW-1:0]    wb_rd_o,
	output logic                                  wb_load_regfile_o,
	output rv32i_types_pkg::regfilemux_sel_e      wb_sel_o,
	output logic [rv32i_types_pkg::XLEN-1:0]      wb_u_imm_o,
	output logic [mem_bus_pkg::DATA_W-1:0]        wb_data_o,
	output logic [mem_bus_pkg::BE_W-1:0]          wb_be_o
);

	logic busy_q, rd_mem_q, wr_mem_q, accept, mem_op;
	rv32i_types_pkg::width_e width_q;
	logic [mem_bus_pkg::ADDR_LSB-1:0] byte_off;

	assign accept = instr_valid_i && !busy_q;	// strobes during a stall are dropped
	assign mem_op = rd_mem_q || wr_mem_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) busy_q <= 1'b0;
		else if (accept) busy_q <= 1'b1;
		else if (wb_valid_o) busy_q <= 1'b0;
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			wb_alu_o          <= alu_i;
			wb_br_en_o        <= br_en_i;
			wb_pc_o           <= pc_i;
			wb_rd_o           <= rd_i;
			rs2_addr_o        <= rs2_i;
			wb_load_regfile_o <= load_regfile_i;
			rd_mem_q          <= mem_read_i;
			wr_mem_q          <= mem_write_i;
			width_q           <= width_i;
			wb_sel_o          <= regfilemux_sel_i;
			wb_u_imm_o        <= u_imm_i;
		end
	end

	// ==================================================
	// byte enables and store lanes
	// ==================================================

	assign byte_off = wb_alu_o[mem_bus_pkg::ADDR_LSB-1:0];

	always_comb begin
		case (width_q)
			rv32i_types_pkg::width_b: begin
				be_o    = 4'b0001 << byte_off;
				wdata_o = {4{rs2_data_i[7:0]}};
			end
			rv32i_types_pkg::width_h: begin
				be_o    = byte_off[1] ? 4'b1100 : 4'b0011;
				wdata_o = {2{rs2_data_i[15:0]}};
			end
			default: begin
				be_o    = 4'b1111;
				wdata_o = rs2_data_i;
			end
		endcase
	end

	assign req_o   = busy_q && mem_op;	// held through the grant cycle
	assign we_o    = wr_mem_q;
	assign addr_o  = wb_alu_o[RAM_AW+mem_bus_pkg::ADDR_LSB-1:mem_bus_pkg::ADDR_LSB];
	assign stall_o = busy_q;

	// memory ops finish on the grant, the rest right away
	assign wb_valid_o = busy_q && (mem_op ? gnt_i : 1'b1);
	assign wb_data_o  = rdata_i;
	assign wb_be_o    = be_o;

endmodule

/* design/regfile.sv */
`timescale 1ns/100ps

module regfile (
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                we_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0] waddr_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]   wdata_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0] raddr_a_i,
	output logic [rv32i_types_pkg::XLEN-1:0]   rdata_a_o,
	input  logic [rv32i_types_pkg::REG_AW-1:0] raddr_b_i,
	output logic [rv32i_types_pkg::XLEN-1:0]   rdata_b_o
);

	logic [rv32i_types_pkg::XLEN-1:0] regs [rv32i_types_pkg::NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < rv32i_types_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin	// x0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// both read ports are combinational
	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

endmodule

/* design/rv32i_backend.sv */
`timescale 1ns/100ps

module rv32i_backend #(
	parameter int RAM_AW = 8
) (
	input  logic                                  clk_i,
	input  logic                                  rst_n_i,
	// instruction from execute
	input  logic                                  instr_valid_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      alu_i,
	input  logic                                  br_en_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      pc_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0]    rd_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0]    rs2_i,
	input  logic                                  load_regfile_i,
	input  logic                                  mem_read_i,
	input  logic                                  mem_write_i,
	input  rv32i_types_pkg::width_e               width_i,
	input  rv32i_types_pkg::regfilemux_sel_e      regfilemux_sel_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      u_imm_i,
	output logic                                  stall_o,
	// host port
	input  logic                                  host_req_i,
	input  logic                                  host_we_i,
	input  logic [RAM_AW-1:0]                     host_addr_i,
	input  logic [mem_bus_pkg::BE_W-1:0]          host_be_i,
	input  logic [mem_bus_pkg::DATA_W-1:0]        host_wdata_i,
	output logic                                  host_ack_o,
	output logic [mem_bus_pkg::DATA_W-1:0]        host_rdata_o,
	// debug and writeback
	input  logic [rv32i_types_pkg::REG_AW-1:0]    dbg_addr_i,
	output logic [rv32i_types_pkg::XLEN-1:0]      dbg_data_o,
	output logic                                  wb_load_o,
	output logic [rv32i_types_pkg::REG_AW-1:0]    wb_rd_o,
	output logic [rv32i_types_pkg::XLEN-1:0]      wb_data_o
);

	logic [rv32i_types_pkg::REG_AW-1:0] rs2_addr;
	logic [rv32i_types_pkg::XLEN-1:0]   rs2_data;

	logic                           pipe_req, pipe_we, pipe_gnt;
	logic [RAM_AW-1:0]              pipe_addr, ram_addr;
	logic [mem_bus_pkg::BE_W-1:0]   pipe_be, ram_be, mem_wb_be;
	logic [mem_bus_pkg::DATA_W-1:0] pipe_wdata, ram_wdata, ram_rdata, mem_wb_data;
	logic                           ram_en, ram_we;

	logic                               mem_wb_valid, mem_wb_br_en, mem_wb_load;
	logic [rv32i_types_pkg::XLEN-1:0]   mem_wb_alu, mem_wb_pc, mem_wb_u_imm;
	logic [rv32i_types_pkg::REG_AW-1:0] mem_wb_rd;
	rv32i_types_pkg::regfilemux_sel_e   mem_wb_sel;

	regfile u_regfile (
		.clk_i, .rst_n_i,
		.we_i(wb_load_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o),
		.raddr_a_i(rs2_addr), .rdata_a_o(rs2_data),
		.raddr_b_i(dbg_addr_i), .rdata_b_o(dbg_data_o)	// debug peek
	);

	mem_stage #(.RAM_AW(RAM_AW)) u_mem_stage (
		.clk_i, .rst_n_i,
		.instr_valid_i, .alu_i, .br_en_i, .pc_i, .rd_i, .rs2_i,
		.load_regfile_i, .mem_read_i, .mem_write_i, .width_i, .regfilemux_sel_i, .u_imm_i,
		.stall_o,
		.rs2_addr_o(rs2_addr), .rs2_data_i(rs2_data),
		.req_o(pipe_req), .we_o(pipe_we), .addr_o(pipe_addr), .be_o(pipe_be),
		.wdata_o(pipe_wdata), .gnt_i(pipe_gnt), .rdata_i(host_rdata_o),
		.wb_valid_o(mem_wb_valid), .wb_alu_o(mem_wb_alu), .wb_br_en_o(mem_wb_br_en),
		.wb_pc_o(mem_wb_pc), .wb_rd_o(mem_wb_rd), .wb_load_regfile_o(mem_wb_load),
		.wb_sel_o(mem_wb_sel), .wb_u_imm_o(mem_wb_u_imm), .wb_data_o(mem_wb_data),
		.wb_be_o(mem_wb_be)
	);

	wb_stage u_wb_stage (
		.clk_i, .rst_n_i,
		.wb_valid_i(mem_wb_valid), .wb_alu_i(mem_wb_alu), .wb_br_en_i(mem_wb_br_en),
		.wb_pc_i(mem_wb_pc), .wb_rd_i(mem_wb_rd), .wb_load_regfile_i(mem_wb_load),
		.wb_sel_i(mem_wb_sel), .wb_u_imm_i(mem_wb_u_imm), .wb_data_i(mem_wb_data),
		.wb_be_i(mem_wb_be),
		.rf_we_o(wb_load_o), .rf_waddr_o(wb_rd_o), .rf_wdata_o(wb_data_o)
	);

	bus_arbiter #(.RAM_AW(RAM_AW)) u_bus_arbiter (
		.clk_i, .rst_n_i,
		.pipe_req_i(pipe_req), .pipe_we_i(pipe_we), .pipe_addr_i(pipe_addr),
		.pipe_be_i(pipe_be), .pipe_wdata_i(pipe_wdata), .pipe_gnt_o(pipe_gnt),
		.host_req_i, .host_we_i, .host_addr_i, .host_be_i, .host_wdata_i,
		.host_gnt_o(host_ack_o),
		.ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_be_o(ram_be),
		.ram_wdata_o(ram_wdata), .rdata_i(ram_rdata), .rdata_o(host_rdata_o)
	);

	data_ram #(.RAM_AW(RAM_AW)) u_data_ram (
		.clk_i, .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr), .be_i(ram_be),
		.wdata_i(ram_wdata), .rdata_o(ram_rdata)
	);

endmodule

/* design/rv32i_types_pkg.sv */
package rv32i_types_pkg;

	// ==================================================
	// datapath widths
	// ==================================================

	localparam int XLEN     = 32;	// data word width
	localparam int REG_AW   = 5;	// register number width
	localparam int NUM_REGS = 32;
	localparam int PC_STEP  = 4;	// bytes per instruction

	// ==================================================
	// decoded control encodings
	// ==================================================

	// writeback source select
	typedef enum logic [3:0] {
		alu_out  = 4'd0,
		br_en    = 4'd1,
		u_imm    = 4'd2,
		lw       = 4'd3,
		pc_plus4 = 4'd4,
		lb       = 4'd5,
		lbu      = 4'd6,
		lh       = 4'd7,
		lhu      = 4'd8
	} regfilemux_sel_e;

	// access width of a load or store
	typedef enum logic [1:0] {
		width_b = 2'b00,
		width_h = 2'b01,
		width_w = 2'b10
	} width_e;

endpackage

/* design/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage (
	input  logic                                  clk_i,
	input  logic                                  rst_n_i,
	input  logic                                  wb_valid_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      wb_alu_i,
	input  logic                                  wb_br_en_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      wb_pc_i,
	input  logic [rv32i_types_pkg::REG_AW-1:0]    wb_rd_i,
	input  logic                                  wb_load_regfile_i,
	input  rv32i_types_pkg::regfilemux_sel_e      wb_sel_i,
	input  logic [rv32i_types_pkg::XLEN-1:0]      wb_u_imm_i,
	input  logic [mem_bus_pkg::DATA_W-1:0]        wb_data_i,
	input  logic [mem_bus_pkg::BE_W-1:0]          wb_be_i,
	output logic                                  rf_we_o,
	output logic [rv32i_types_pkg::REG_AW-1:0]    rf_waddr_o,
	output logic [rv32i_types_pkg::XLEN-1:0]      rf_wdata_o
);

	logic [7:0]  byte_lane;
	logic [15:0] half_lane;
	logic [rv32i_types_pkg::XLEN-1:0] wb_value;

	// ==================================================
	// pick the lane named by the byte enables
	// ==================================================

	always_comb begin
		case (wb_be_i)
			4'b0010: byte_lane = wb_data_i[15:8];
			4'b0100: byte_lane = wb_data_i[23:16];
			4'b1000: byte_lane = wb_data_i[31:24];
			default: byte_lane = wb_data_i[7:0];
		endcase
	end

	assign half_lane = (wb_be_i == 4'b1100) ? wb_data_i[31:16] : wb_data_i[15:0];

	// ==================================================
	// writeback mux
	// ==================================================

	always_comb begin
		unique case (wb_sel_i)
			rv32i_types_pkg::alu_out:  wb_value = wb_alu_i;
			rv32i_types_pkg::br_en:    wb_value = {31'b0, wb_br_en_i};
			rv32i_types_pkg::u_imm:    wb_value = wb_u_imm_i;
			rv32i_types_pkg::lw:       wb_value = wb_data_i;
			rv32i_types_pkg::pc_plus4: wb_value = wb_pc_i + rv32i_types_pkg::PC_STEP;
			rv32i_types_pkg::lb:       wb_value = {{24{byte_lane[7]}}, byte_lane};
			rv32i_types_pkg::lbu:      wb_value = {24'b0, byte_lane};
			rv32i_types_pkg::lh:       wb_value = {{16{half_lane[15]}}, half_lane};
			rv32i_types_pkg::lhu:      wb_value = {16'b0, half_lane};
			default:                   wb_value = wb_alu_i;	// unused encodings
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) rf_we_o <= 1'b0;
		else rf_we_o <= wb_valid_i && wb_load_regfile_i;
	end

	always_ff @(posedge clk_i) begin
		if (wb_valid_i) begin
			rf_waddr_o <= wb_rd_i;
			rf_wdata_o <= wb_value;
		end
	end

endmodule

/* dv/backend_checker.sv */
`timescale 1ns/100ps

module backend_checker #(
	parameter int RAM_AW = 8
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              instr_valid_i,
	input  logic              stall_i,
	input  logic [31:0]       alu_i,
	input  logic [4:0]        rd_i,
	input  logic [4:0]        rs2_i,
	input  logic              load_regfile_i,
	input  logic              mem_write_i,
	input  logic [1:0]        width_i,
	input  logic [31:0]       exp_data_i,	// table value for this instruction
	input  logic              wb_load_i,
	input  logic [4:0]        wb_rd_i,
	input  logic [31:0]       wb_data_i,
	input  logic [31:0]       dbg_data_i,
	input  logic              host_req_i,
	input  logic              host_we_i,
	input  logic [RAM_AW-1:0] host_addr_i,
	input  logic [3:0]        host_be_i,
	input  logic [31:0]       host_wdata_i,
	input  logic              host_ack_i,
	input  logic [31:0]       host_rdata_i,
	output int                errors_o,
	output int                checks_o
);

	logic [31:0] ref_mem [2**RAM_AW];
	logic [31:0] shadow [32];	// register values as the table predicts them
	logic        pend, pend_load, got_wb;
	logic [4:0]  pend_rd;
	logic [31:0] pend_exp;
	int          errors, checks;

	assign errors_o = errors;
	assign checks_o = checks;

	initial begin
		errors = 0;
		checks = 0;
		pend = 1'b0;
		got_wb = 1'b0;
		for (int i = 0; i < 32; i++) shadow[i] = '0;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED time=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// store rule: byte, half or word placed at the addressed lanes
	task automatic apply_store(input logic [31:0] addr, input logic [1:0] w, input logic [31:0] v);
		logic [RAM_AW-1:0] wa;
		wa = addr[RAM_AW+1:2];
		case (w)
			2'd0: ref_mem[wa][addr[1:0]*8 +: 8] = v[7:0];
			2'd1: ref_mem[wa][addr[1]*16 +: 16] = v[15:0];
			default: ref_mem[wa] = v;
		endcase
	endtask

	// ==================================================
	// per-cycle monitor
	// ==================================================

	always @(posedge clk_i) begin
		if (rst_n_i) begin
			compare("dbg_data_o", dbg_data_i, 32'h0);	// debug port reads x0
			if (wb_load_i) begin
				if (!pend || !pend_load) begin
					errors++;
					$display("register write at time %0t with no writeback expected", $time);
				end else begin
					compare("wb_rd_o", {27'b0, wb_rd_i}, {27'b0, pend_rd});
					compare("wb_data_o", wb_data_i, pend_exp);
					got_wb = 1'b1;
				end
			end
			if (pend && !stall_i) begin
				if (pend_load && !got_wb) begin
					errors++;
					$display("instruction ended at time %0t without its register write", $time);
				end
				pend = 1'b0;
			end
			if (instr_valid_i && !stall_i) begin
				pend      = 1'b1;
				pend_load = load_regfile_i;
				pend_rd   = rd_i;
				pend_exp  = exp_data_i;
				got_wb    = 1'b0;
				if (mem_write_i) apply_store(alu_i, width_i, shadow[rs2_i]);
				if (load_regfile_i && rd_i != 5'd0) shadow[rd_i] = exp_data_i;
			end
			if (host_ack_i) begin
				if (!host_req_i) begin
					errors++;
					$display("host ack at time %0t without a host request", $time);
				end else if (host_we_i) begin
					for (int b = 0; b < 4; b++)
						if (host_be_i[b]) ref_mem[host_addr_i][b*8 +: 8] = host_wdata_i[b*8 +: 8];
				end else begin
					compare("host_rdata_o", host_rdata_i, ref_mem[host_addr_i]);
				end
			end
		end
	end

endmodule

/* dv/backend_chk.sv */
`timescale 1ns/100ps

module backend_chk (
	input logic clk_i,
	input logic rst_n_i,
	input logic pipe_req_i,
	input logic pipe_gnt_i,
	input logic host_req_i,
	input logic host_gnt_i
);

	int fails = 0;	// failed assertions so far

	// at most one grant in any cycle, and only for a requester that asked
	a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({pipe_gnt_i, host_gnt_i})
		&& (!pipe_gnt_i || $past(pipe_req_i))
		&& (!host_gnt_i || $past(host_req_i)))
		else begin
			fails++;
			$error("grant not one-hot or not backed by a request");
		end

	a_pipe_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pipe_req_i |-> ##[0:4] pipe_gnt_i)
		else begin
			fails++;
			$error("pipe request not granted within 4 cycles");
		end

	a_host_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		host_req_i |-> ##[0:4] host_gnt_i)
		else begin
			fails++;
			$error("host request not granted within 4 cycles");
		end

	// an instruction in flight keeps its request until the grant
	a_pipe_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pipe_req_i && !pipe_gnt_i |=> pipe_req_i)
		else begin
			fails++;
			$error("pipe request dropped before its grant");
		end

endmodule

/* dv/tb_rv32i_backend.sv */
`timescale 1ns/100ps

module tb_rv32i_backend;

	localparam int RAM_AW = 8;
	localparam int TMO    = 40;	// cycles per wait

	logic        clk_i, rst_n_i;
	logic        instr_valid, br_en, load_rf, mem_rd, mem_wr, stall;
	logic [31:0] alu, pc, u_imm, cur_exp;
	logic [4:0]  rd, rs2, dbg_addr;
	rv32i_types_pkg::width_e          width;
	rv32i_types_pkg::regfilemux_sel_e sel;
	logic              host_req, host_we, host_ack;
	logic [RAM_AW-1:0] host_addr;
	logic [3:0]        host_be;
	logic [31:0]       host_wdata, host_rdata, dbg_data, wb_data;
	logic              wb_load;
	logic [4:0]        wb_rd;
	int                errors, checks, seed, asrt_fails;

	// stimulus table
	logic [3:0]  t_sel [$];
	logic [3:0]  t_ctl [$];	// load_regfile, mem_read, mem_write, br_en
	logic [1:0]  t_width [$];
	logic [31:0] t_alu [$];
	logic [31:0] t_imm [$];	// both pc and u-immediate
	logic [4:0]  t_rd [$];
	logic [31:0] t_exp [$];

	rv32i_backend #(.RAM_AW(RAM_AW)) dut0 (
		.clk_i, .rst_n_i, .instr_valid_i(instr_valid), .alu_i(alu), .br_en_i(br_en),
		.pc_i(pc), .rd_i(rd), .rs2_i(rs2), .load_regfile_i(load_rf), .mem_read_i(mem_rd),
		.mem_write_i(mem_wr), .width_i(width), .regfilemux_sel_i(sel), .u_imm_i(u_imm),
		.stall_o(stall), .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
		.host_be_i(host_be), .host_wdata_i(host_wdata), .host_ack_o(host_ack),
		.host_rdata_o(host_rdata), .dbg_addr_i(dbg_addr), .dbg_data_o(dbg_data),
		.wb_load_o(wb_load), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
	);

	backend_checker #(.RAM_AW(RAM_AW)) u_checker (
		.clk_i, .rst_n_i, .instr_valid_i(instr_valid), .stall_i(stall), .alu_i(alu),
		.rd_i(rd), .rs2_i(rs2), .load_regfile_i(load_rf), .mem_write_i(mem_wr),
		.width_i(width), .exp_data_i(cur_exp), .wb_load_i(wb_load), .wb_rd_i(wb_rd),
		.wb_data_i(wb_data), .dbg_data_i(dbg_data), .host_req_i(host_req),
		.host_we_i(host_we), .host_addr_i(host_addr), .host_be_i(host_be),
		.host_wdata_i(host_wdata), .host_ack_i(host_ack), .host_rdata_i(host_rdata),
		.errors_o(errors), .checks_o(checks)
	);

	bind bus_arbiter backend_chk u_backend_chk (
		.clk_i, .rst_n_i, .pipe_req_i, .pipe_gnt_i(pipe_gnt_o), .host_req_i,
		.host_gnt_i(host_gnt_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	function automatic void add_row(input logic [3:0] s, input logic [3:0] c,
			input logic [1:0] w, input logic [31:0] a, input logic [31:0] i,
			input logic [4:0] r, input logic [31:0] e);
		t_sel.push_back(s);
		t_ctl.push_back(c);
		t_width.push_back(w);
		t_alu.push_back(a);
		t_imm.push_back(i);
		t_rd.push_back(r);
		t_exp.push_back(e);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("errors=%0d checks=%0d", errors, checks);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic host_access(input logic we, input logic [RAM_AW-1:0] a, input logic [31:0] d);
		int n;
		@(negedge clk_i);
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = a;
		host_be    = 4'hf;
		host_wdata = d;
		n = 0;
		@(negedge clk_i);
		while (!host_ack && n < TMO) begin
			@(negedge clk_i);
			n++;
		end
		if (!host_ack) begin
			abort_run("host access got no ack in time");
		end else begin
			@(negedge clk_i);	// request stays up through the ack cycle
			host_req = 1'b0;
		end
	endtask

	task automatic issue_row(input int i);
		int n;
		@(negedge clk_i);
		instr_valid = 1'b1;
		sel     = rv32i_types_pkg::regfilemux_sel_e'(t_sel[i]);
		width   = rv32i_types_pkg::width_e'(t_width[i]);
		{load_rf, mem_rd, mem_wr, br_en} = t_ctl[i];
		alu     = t_alu[i];
		pc      = t_imm[i];
		u_imm   = t_imm[i];
		rd      = t_rd[i];
		cur_exp = t_exp[i];
		@(negedge clk_i);
		instr_valid = 1'b0;
		n = 0;
		while (stall && n < TMO) begin
			@(negedge clk_i);
			n++;
		end
		if (stall) abort_run("instruction did not finish in time");
	endtask

	task automatic host_noise();
		int                gap;
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [31:0]       data;
		for (int k = 0; k < 30; k++) begin
			gap  = $unsigned($random(seed)) % 4;
			we   = $random(seed) % 2 != 0;
			addr = RAM_AW'(128 + $unsigned($random(seed)) % 8);
			data = $random(seed);
			repeat (gap) @(negedge clk_i);
			host_access(we, addr, data);
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		seed = 32'hb7e4;
		{instr_valid, br_en, load_rf, mem_rd, mem_wr} = '0;
		{alu, pc, u_imm, cur_exp} = '0;
		rd = '0;
		rs2 = 5'd5;	// every store takes x5
		dbg_addr = 5'd0;
		width = rv32i_types_pkg::width_w;
		sel = rv32i_types_pkg::alu_out;
		{host_req, host_we, host_addr, host_be, host_wdata} = '0;
		rst_n_i = 1'b0;

		// sel  ctl      w     alu           imm            rd     expected
		add_row(4'd0, 4'b1000, 2'd2, 32'ha1b2_c3d4, 32'h0, 5'd5, 32'ha1b2_c3d4);
		add_row(4'd1, 4'b1001, 2'd2, 32'h0, 32'h0, 5'd6, 32'h0000_0001);
		add_row(4'd2, 4'b1000, 2'd2, 32'h0, 32'h1234_5000, 5'd7, 32'h1234_5000);
		add_row(4'd4, 4'b1000, 2'd2, 32'h0, 32'h0000_0100, 5'd8, 32'h0000_0104);
		add_row(4'd0, 4'b1000, 2'd2, 32'hdead_beef, 32'h0, 5'd0, 32'hdead_beef);	// x0
		add_row(4'd0, 4'b0000, 2'd2, 32'h5555_aaaa, 32'h0, 5'd9, 32'h0);
		add_row(4'd5, 4'b1100, 2'd0, 32'h0, 32'h0, 5'd10, 32'hffff_ff92);
		add_row(4'd6, 4'b1100, 2'd0, 32'h0, 32'h0, 5'd10, 32'h0000_0092);
		add_row(4'd5, 4'b1100, 2'd0, 32'h1, 32'h0, 5'd11, 32'h0000_007f);
		add_row(4'd6, 4'b1100, 2'd0, 32'h1, 32'h0, 5'd11, 32'h0000_007f);
		add_row(4'd5, 4'b1100, 2'd0, 32'h2, 32'h0, 5'd12, 32'hffff_fff1);
		add_row(4'd6, 4'b1100, 2'd0, 32'h2, 32'h0, 5'd12, 32'h0000_00f1);
		add_row(4'd5, 4'b1100, 2'd0, 32'h3, 32'h0, 5'd13, 32'hffff_ff80);
		add_row(4'd6, 4'b1100, 2'd0, 32'h3, 32'h0, 5'd13, 32'h0000_0080);
		add_row(4'd7, 4'b1100, 2'd1, 32'h0, 32'h0, 5'd14, 32'h0000_7f92);
		add_row(4'd8, 4'b1100, 2'd1, 32'h0, 32'h0, 5'd14, 32'h0000_7f92);
		add_row(4'd7, 4'b1100, 2'd1, 32'h2, 32'h0, 5'd15, 32'hffff_80f1);
		add_row(4'd8, 4'b1100, 2'd1, 32'h2, 32'h0, 5'd15, 32'h0000_80f1);
		add_row(4'd3, 4'b1100, 2'd2, 32'h0, 32'h0, 5'd16, 32'h80f1_7f92);
		add_row(4'd0, 4'b0010, 2'd0, 32'h15, 32'h0, 5'd0, 32'h0);	// sb
		add_row(4'd0, 4'b0010, 2'd1, 32'h1a, 32'h0, 5'd0, 32'h0);	// sh
		add_row(4'd0, 4'b0010, 2'd2, 32'h1c, 32'h0, 5'd0, 32'h0);	// sw

		repeat (5) @(negedge clk_i);
		rst_n_i = 1'b1;

		host_access(1'b1, 8'd0, 32'h80f1_7f92);
		host_access(1'b1, 8'd5, 32'h1122_3344);
		host_access(1'b1, 8'd6, 32'h5566_7788);
		host_access(1'b1, 8'd7, 32'h99aa_bbcc);
		for (int a = 128; a < 136; a++) begin
			host_access(1'b1, a[7:0], $random(seed) ^ (a * 32'h0101_0101));
		end

		fork
			for (int i = 0; i < t_sel.size(); i++) issue_row(i);
			host_noise();
		join

		for (int a = 5; a < 8; a++) host_access(1'b0, a[7:0], 32'h0);	// read back the stores
		host_access(1'b0, 8'd0, 32'h0);
		repeat (4) @(negedge clk_i);

		asrt_fails = dut0.u_bus_arbiter.u_backend_chk.fails;
		$display("errors=%0d assertion_fails=%0d checks=%0d", errors, asrt_fails, checks);
		if (errors == 0 && asrt_fails == 0 && checks > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* rv32i_backend.f */
design/rv32i_types_pkg.sv
design/mem_bus_pkg.sv
design/regfile.sv
design/data_ram.sv
design/bus_arbiter.sv
design/mem_stage.sv
design/wb_stage.sv
design/rv32i_backend.sv
dv/backend_chk.sv
dv/backend_checker.sv
dv/tb_rv32i_backend.sv
